// ==== verilog.f ====
hw/fp_pkg.sv
hw/byte_replay.sv
hw/context_tracker.sv
hw/pattern_bank.sv
hw/match_select.sv
hw/fast_pattern_top.sv
tests/tb_fast_pattern.sv
+incdir+include

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module tb_fast_pattern -o tb_fast_pattern &&
  ./obj_dir/tb_fast_pattern > sim.log 2>&1 &&
  cat sim.log &&
  grep -qx "Everything OK" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed, see sim.log"; exit 1; }

// ==== include/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////
// Bytes fed to the banks since the last reload
byte_t                 fed_q[$];
// Every live byte with the newest at the back
byte_t                 live_q[$];
int                    live_count = 0;
logic [TOTAL_BINS-1:0] model_mask = '1;

function automatic logic pattern_hits(int p);
  int   len;
  logic same;
  len  = int'(PAT_LEN[p]);
  same = (fed_q.size() >= len);
  for (int i = 0; i < len; i++) begin
    if (same && fed_q[fed_q.size() - 1 - i] != PAT_BYTES[p][i*8 +: 8]) begin
      same = 1'b0;
    end
  end
  return same;
endfunction

// Bin b covers global patterns 2b and 2b+1
function automatic logic [TOTAL_BINS-1:0] model_bins(logic both);
  logic [TOTAL_BINS-1:0] v;
  for (int b = 0; b < TOTAL_BINS; b++) begin
    if (both) begin
      v[b] = pattern_hits(2 * b) & pattern_hits(2 * b + 1);
    end else begin
      v[b] = pattern_hits(2 * b) | pattern_hits(2 * b + 1);
    end
  end
  return v;
endfunction

function automatic int model_first_bin();
  logic [TOTAL_BINS-1:0] pending;
  int                    first;
  pending = model_bins(1'b0) & model_mask;
  first   = -1;
  for (int b = TOTAL_BINS - 1; b >= 0; b--) begin
    if (pending[b]) begin
      first = b;
    end
  end
  return first;
endfunction

function automatic ctx_t model_context();
  ctx_t c;
  c      = '0;
  c[7:0] = 8'(live_count);
  for (int k = 1; k <= 7; k++) begin
    if (live_q.size() >= k) begin
      c[k*8 +: 8] = live_q[live_q.size() - k];
    end
  end
  return c;
endfunction

//////////////////////////////////////////////////
// Stimulus
//////////////////////////////////////////////////
task automatic send_live(byte_t b);
  live_q.push_back(b);
  fed_q.push_back(b);
  if (live_count < 7) begin
    live_count++;
  end
  data       = b;
  data_valid = 1'b1;
  @(negedge clk);
  data_valid = 1'b0;
endtask

task automatic send_text(string s);
  for (int i = 0; i < s.len(); i++) begin
    send_live(byte_t'(s[i]));
  end
endtask

task automatic send_filler(int n);
  for (int i = 0; i < n; i++) begin
    send_live(filler_byte());
  end
endtask

task automatic do_reload(ctx_t ctx);
  int count;
  count = int'(ctx[2:0]);
  fed_q.delete();
  // Saved bytes replay oldest first
  for (int k = count; k >= 1; k--) begin
    fed_q.push_back(ctx[k*8 +: 8]);
  end
  live_count = 0;
  model_mask = '1;
  context_in = ctx;
  reload     = 1'b1;
  @(negedge clk);
  reload = 1'b0;
  // Live bytes are ignored until the saved bytes have gone out
  repeat (count) @(negedge clk);
endtask

task automatic pulse_next();
  int b;
  b = model_first_bin();
  if (b >= 0) begin
    model_mask[b] = 1'b0;
  end
  next_index = 1'b1;
  @(negedge clk);
  next_index = 1'b0;
  @(negedge clk);
endtask

// Window edge, then bin registers, then output registers
task automatic settle();
  repeat (2) @(negedge clk);
endtask

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////
task automatic check_index(string name, pat_id_t expected, pat_id_t actual);
  if (actual !== expected) begin
    $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    error_count++;
  end
endtask

task automatic check_flag(string name, logic expected, logic actual);
  if (actual !== expected) begin
    $display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
    error_count++;
  end
endtask

task automatic check_bins(string name, logic [TOTAL_BINS-1:0] expected,
                          logic [TOTAL_BINS-1:0] actual);
  if (actual !== expected) begin
    $display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
    error_count++;
  end
endtask

task automatic check_context(string name, ctx_t expected, ctx_t actual);
  if (actual !== expected) begin
    $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    error_count++;
  end
endtask

// Every match output against the model
task automatic check_outputs();
  logic [TOTAL_BINS-1:0] multi;
  int                    first;
  multi = model_bins(1'b1);
  first = model_first_bin();
  check_flag("match_valid", first >= 0, match_valid);
  if (first >= 0) begin
    check_index("match_index", pattern_hits(2 * first) ? pat_id_t'(2 * first) :
                pat_id_t'(2 * first + 1), match_index);
    check_flag("match_error", multi[first], match_error);
  end else begin
    check_flag("match_error", 1'b0, match_error);
  end
  check_bins("bin_valid", model_bins(1'b0) & model_mask, bin_valid);
  check_bins("bin_error", multi & model_mask, bin_error);
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////
task automatic test_single_hit();
  do_reload('0);
  send_filler(6);
  settle();
  check_flag("match_valid", 1'b0, match_valid);
  send_text("fish");
  settle();
  check_flag("match_valid", 1'b1, match_valid);
  check_index("match_index", 4'd4, match_index);
  check_flag("match_error", 1'b0, match_error);
  check_bins("bin_valid", 8'b0000_0100, bin_valid);
  check_outputs();
endtask

// wxyz in bank 0 and yz in bank 1 end on the same byte
task automatic test_both_banks();
  do_reload('0);
  send_filler(3);
  send_text("wxyz");
  settle();
  check_index("match_index", 4'd7, match_index);
  check_bins("bin_valid", 8'b0001_1000, bin_valid);
  check_outputs();
  pulse_next();
  check_flag("match_valid", 1'b1, match_valid);
  check_index("match_index", 4'd9, match_index);
  check_outputs();
  pulse_next();
  check_flag("match_valid", 1'b0, match_valid);
  check_outputs();
endtask

task automatic test_bin_collision();
  do_reload('0);
  send_filler(2);
  send_text("ab");
  settle();
  check_index("match_index", 4'd2, match_index);
  check_flag("match_error", 1'b1, match_error);
  check_flag("bin_error[1]", 1'b1, bin_error[1]);
  check_outputs();
endtask

task automatic test_context_capture();
  int n;
  do_reload('0);
  n = 1 + int'(next_random() % 32'd12);
  send_filler(n);
  check_context("context_out", model_context(), context_out);
endtask

// Pattern kiwi split across a reload
task automatic test_replay_gap();
  ctx_t saved;
  do_reload('0);
  send_filler(3);
  send_text("ki");
  settle();
  check_flag("match_valid", 1'b0, match_valid);
  check_context("context_out", model_context(), context_out);
  saved = model_context();
  do_reload(saved);
  send_text("wi");
  settle();
  check_flag("match_valid", 1'b1, match_valid);
  check_index("match_index", 4'd8, match_index);
  check_outputs();
endtask

// After fish a lone q would finish hq if the window survived
task automatic test_reload_clear();
  do_reload('0);
  send_text("fish");
  settle();
  check_flag("match_valid", 1'b1, match_valid);
  do_reload('0);
  check_flag("match_valid", 1'b0, match_valid);
  check_context("context_out", model_context(), context_out);
  send_text("q");
  settle();
  check_flag("match_valid", 1'b0, match_valid);
  check_outputs();
endtask

`endif

// ==== tests/tb_fast_pattern.sv ====
module tb_fast_pattern;

  import fp_pkg::*;

  // Rough sum of all test lengths in cycles with margin
  localparam int TEST_CYCLES = 500;
  localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

  logic                  clk = 1'b0;
  logic                  rst;
  byte_t                 data;
  logic                  data_valid;
  ctx_t                  context_in;
  logic                  reload;
  logic                  next_index;
  pat_id_t               match_index;
  logic                  match_valid;
  logic                  match_error;
  ctx_t                  context_out;
  logic [TOTAL_BINS-1:0] bin_valid;
  logic [TOTAL_BINS-1:0] bin_error;

  int          error_count = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;
  int          mark;
  int          cycle_count;
  int unsigned lcg_state   = 77;

  fast_pattern_top fast_pattern_top_i (
    .clk         (clk),
    .rst         (rst),
    .data        (data),
    .data_valid  (data_valid),
    .context_in  (context_in),
    .reload      (reload),
    .next_index  (next_index),
    .match_index (match_index),
    .match_valid (match_valid),
    .match_error (match_error),
    .context_out (context_out),
    .bin_valid   (bin_valid),
    .bin_error   (bin_error)
  );

  // Linear congruential generator
  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // No upper case letter is a pattern byte
  function automatic byte_t filler_byte();
    return byte_t'(32'h41 + next_random() % 32'd26);
  endfunction

  `include "tb_tasks.svh"

  initial begin
    forever #20 clk = ~clk;
  end

  task automatic report_test(string name, int errors_before);
    if (error_count == errors_before) begin
      pass_count++;
      $display("Test %s passed", name);
    end else begin
      fail_count++;
      $display("Test %s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    rst        = 1'b1;
    data       = '0;
    data_valid = 1'b0;
    context_in = '0;
    reload     = 1'b0;
    next_index = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    mark = error_count;
    test_single_hit();
    report_test("single hit", mark);
    mark = error_count;
    test_both_banks();
    report_test("both banks", mark);
    mark = error_count;
    test_bin_collision();
    report_test("bin collision", mark);
    mark = error_count;
    test_context_capture();
    report_test("context capture", mark);
    mark = error_count;
    test_replay_gap();
    report_test("replay across gap", mark);
    mark = error_count;
    test_reload_clear();
    report_test("reload clear", mark);
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== hw/fast_pattern_top.sv ====
module fast_pattern_top (
  input  logic                              clk,
  input  logic                              rst,

  // Byte stream
  input  fp_pkg::byte_t                     data,
  input  logic                              data_valid,

  // Saved context to resume from
  input  fp_pkg::ctx_t                      context_in,
  input  logic                              reload,

  // Reported match
  input  logic                              next_index,
  output fp_pkg::pat_id_t                   match_index,
  output logic                              match_valid,
  output logic                              match_error,

  // Context of the live stream
  output fp_pkg::ctx_t                      context_out,

  // Per-bin status, bank 0 in the low half
  output logic [fp_pkg::TOTAL_BINS-1:0]     bin_valid,
  output logic [fp_pkg::TOTAL_BINS-1:0]     bin_error
);

  import fp_pkg::*;

  byte_t                      feed_data;
  logic                       feed_valid;
  pat_id_t [TOTAL_BINS-1:0]   bin_index;
  logic    [TOTAL_BINS-1:0]   bin_hit;
  logic    [TOTAL_BINS-1:0]   bin_multi;

  ////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////
  byte_replay byte_replay_i (
    .clk        (clk),
    .rst        (rst),
    .data       (data),
    .data_valid (data_valid),
    .context_in (context_in),
    .reload     (reload),
    .feed_data  (feed_data),
    .feed_valid (feed_valid)
  );

  context_tracker context_tracker_i (
    .clk         (clk),
    .rst         (rst),
    .data        (data),
    .data_valid  (data_valid),
    .reload      (reload),
    .context_out (context_out)
  );

  ////////////////////////////////////////////////////
  // Pattern banks
  ////////////////////////////////////////////////////
  pattern_bank #(
    .BANK_BASE (0)
  ) bank0_i (
    .clk        (clk),
    .rst        (rst),
    .reload     (reload),
    .feed_data  (feed_data),
    .feed_valid (feed_valid),
    .bin_index  (bin_index[BANK_BINS-1:0]),
    .bin_hit    (bin_hit[BANK_BINS-1:0]),
    .bin_multi  (bin_multi[BANK_BINS-1:0])
  );

  pattern_bank #(
    .BANK_BASE (BANK_PATTERNS)
  ) bank1_i (
    .clk        (clk),
    .rst        (rst),
    .reload     (reload),
    .feed_data  (feed_data),
    .feed_valid (feed_valid),
    .bin_index  (bin_index[TOTAL_BINS-1:BANK_BINS]),
    .bin_hit    (bin_hit[TOTAL_BINS-1:BANK_BINS]),
    .bin_multi  (bin_multi[TOTAL_BINS-1:BANK_BINS])
  );

  match_select match_select_i (
    .clk         (clk),
    .rst         (rst),
    .reload      (reload),
    .next_index  (next_index),
    .bin_index   (bin_index),
    .bin_hit     (bin_hit),
    .bin_multi   (bin_multi),
    .match_index (match_index),
    .match_valid (match_valid),
    .match_error (match_error),
    .bin_valid   (bin_valid),
    .bin_error   (bin_error)
  );

endmodule

// ==== hw/match_select.sv ====
module match_select (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      reload,
  input  logic                                      next_index,
  input  fp_pkg::pat_id_t [fp_pkg::TOTAL_BINS-1:0]  bin_index,
  input  logic            [fp_pkg::TOTAL_BINS-1:0]  bin_hit,
  input  logic            [fp_pkg::TOTAL_BINS-1:0]  bin_multi,
  output fp_pkg::pat_id_t                           match_index,
  output logic                                      match_valid,
  output logic                                      match_error,
  output logic            [fp_pkg::TOTAL_BINS-1:0]  bin_valid,
  output logic            [fp_pkg::TOTAL_BINS-1:0]  bin_error
);

  import fp_pkg::*;

  // Bins still open for reporting
  logic    [TOTAL_BINS-1:0] mask;
  logic    [TOTAL_BINS-1:0] live_hit;
  // One-hot bin chosen this cycle and the one currently reported
  logic    [TOTAL_BINS-1:0] sel_bin;
  logic    [TOTAL_BINS-1:0] reported_bin;
  pat_id_t                  sel_index;
  logic                     sel_error;

  ////////////////////////////////////////////////////
  // Lowest unmasked bin
  ////////////////////////////////////////////////////
  assign live_hit = bin_hit & mask;

  always_comb begin
    sel_bin   = '0;
    sel_index = bin_index[0];
    sel_error = 1'b0;
    // Walk downward so the lowest hitting bin is the last to win
    for (int k = TOTAL_BINS - 1; k >= 0; k--) begin
      if (live_hit[k]) begin
        sel_bin    = '0;
        sel_bin[k] = 1'b1;
        sel_index  = bin_index[k];
        sel_error  = bin_multi[k];
      end
    end
  end

  ////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || reload) begin
      match_valid  <= 1'b0;
      match_error  <= 1'b0;
      bin_valid    <= '0;
      bin_error    <= '0;
      reported_bin <= '0;
    end else begin
      match_valid  <= |live_hit;
      match_error  <= sel_error;
      bin_valid    <= live_hit;
      bin_error    <= bin_multi & mask;
      reported_bin <= sel_bin;
    end
  end

  always_ff @(posedge clk) begin
    match_index <= sel_index;
  end

  // next_index retires the bin on display
  always_ff @(posedge clk) begin
    if (rst || reload) begin
      mask <= '1;
    end else if (next_index) begin
      mask <= mask & ~reported_bin;
    end
  end

endmodule

// ==== hw/pattern_bank.sv ====
module pattern_bank #(
  parameter int BANK_BASE = 0
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     reload,
  input  fp_pkg::byte_t                            feed_data,
  input  logic                                     feed_valid,
  output fp_pkg::pat_id_t [fp_pkg::BANK_BINS-1:0]  bin_index,
  output logic            [fp_pkg::BANK_BINS-1:0]  bin_hit,
  output logic            [fp_pkg::BANK_BINS-1:0]  bin_multi
);

  import fp_pkg::*;

  ////////////////////////////////////////////////////
  // Match window
  ////////////////////////////////////////////////////
  // Bits 7:0 hold the newest byte, same order as the pattern table
  logic [PAT_MAX_LEN*8-1:0] window;
  // Number of valid bytes in the window, 0 to 4
  logic [2:0]               fill;

  always_ff @(posedge clk) begin
    if (rst || reload) begin
      window <= '0;
      fill   <= 3'd0;
    end else if (feed_valid) begin
      window <= {window[(PAT_MAX_LEN-1)*8-1:0], feed_data};
      if (fill != 3'(PAT_MAX_LEN)) begin
        fill <= fill + 3'd1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Pattern compare
  ////////////////////////////////////////////////////
  // Only the first len bytes of a pattern take part
  function automatic logic pat_equal(
    input logic [PAT_MAX_LEN*8-1:0] win,
    input logic [PAT_MAX_LEN*8-1:0] pat,
    input logic [2:0]               len
  );
    logic same;
    same = 1'b1;
    for (int b = 0; b < PAT_MAX_LEN; b++) begin
      if (b < int'(len) && win[b*8 +: 8] != pat[b*8 +: 8]) begin
        same = 1'b0;
      end
    end
    return same;
  endfunction

  logic [BANK_PATTERNS-1:0] hit;

  always_comb begin
    for (int p = 0; p < BANK_PATTERNS; p++) begin
      // A short window cannot hold a longer pattern
      hit[p] = (fill >= PAT_LEN[BANK_BASE + p]) &&
               pat_equal(window, PAT_BYTES[BANK_BASE + p], PAT_LEN[BANK_BASE + p]);
    end
  end

  ////////////////////////////////////////////////////
  // Bin encoders
  ////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || reload) begin
      bin_hit   <= '0;
      bin_multi <= '0;
    end else begin
      for (int b = 0; b < BANK_BINS; b++) begin
        bin_hit[b]   <= hit[2*b] | hit[2*b+1];
        // Two hits in one bin, only the lower one can be reported
        bin_multi[b] <= hit[2*b] & hit[2*b+1];
      end
    end
  end

  // Lower id of the pair wins
  always_ff @(posedge clk) begin
    for (int b = 0; b < BANK_BINS; b++) begin
      if (hit[2*b]) begin
        bin_index[b] <= pat_id_t'(BANK_BASE + 2*b);
      end else begin
        bin_index[b] <= pat_id_t'(BANK_BASE + 2*b + 1);
      end
    end
  end

endmodule

// ==== hw/context_tracker.sv ====
module context_tracker (
  input  logic          clk,
  input  logic          rst,
  input  fp_pkg::byte_t data,
  input  logic          data_valid,
  input  logic          reload,
  output fp_pkg::ctx_t  context_out
);

  import fp_pkg::*;

  // Entry 0 is the newest live byte
  byte_t [6:0] hist;
  logic  [2:0] count;

  // History shifts on every live byte
  always_ff @(posedge clk) begin
    if (data_valid) begin
      hist <= {hist[5:0], data};
    end
  end

  // Count of valid history bytes, saturating at 7
  always_ff @(posedge clk) begin
    if (rst || reload) begin
      count <= 3'd0;
    end else if (data_valid && count != 3'd7) begin
      count <= count + 3'd1;
    end
  end

  // Byte 1 of the context word is the newest byte
  assign context_out = {hist, 5'd0, count};

endmodule

// ==== hw/byte_replay.sv ====
module byte_replay (
  input  logic          clk,
  input  logic          rst,
  input  fp_pkg::byte_t data,
  input  logic          data_valid,
  input  fp_pkg::ctx_t  context_in,
  input  logic          reload,
  output fp_pkg::byte_t feed_data,
  output logic          feed_valid
);

  import fp_pkg::*;

  ////////////////////////////////////////////////////
  // Replay counter
  ////////////////////////////////////////////////////
  // Counts the history bytes still to be replayed
  logic [2:0]     replay_cnt;
  // History bytes of the loaded context, entry 0 is the newest
  byte_t [6:0]    saved_hist;

  always_ff @(posedge clk) begin
    if (rst) begin
      replay_cnt <= 3'd0;
    end else if (reload) begin
      replay_cnt <= context_in[2:0];
    end else if (replay_cnt != 3'd0) begin
      replay_cnt <= replay_cnt - 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reload) begin
      saved_hist <= context_in[63:8];
    end
  end

  ////////////////////////////////////////////////////
  // Byte source select
  ////////////////////////////////////////////////////
  // Oldest saved byte goes out first, live data waits until the count runs out
  always_comb begin
    if (replay_cnt != 3'd0) begin
      feed_data  = saved_hist[replay_cnt - 3'd1];
      feed_valid = 1'b1;
    end else begin
      feed_data  = data;
      feed_valid = data_valid;
    end
  end

endmodule

// ==== hw/fp_pkg.sv ====
package fp_pkg;

  ////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////
  localparam int NUM_PATTERNS  = 16;
  localparam int BANK_PATTERNS = 8;
  // Two neighbouring patterns share one bin
  localparam int BANK_BINS     = BANK_PATTERNS / 2;
  localparam int TOTAL_BINS    = 2 * BANK_BINS;
  localparam int PAT_MAX_LEN   = 4;

  typedef logic [7:0]  byte_t;
  // Byte 0 is the count, bytes 1..7 the history with byte 1 newest
  typedef logic [63:0] ctx_t;
  typedef logic [3:0]  pat_id_t;

  ////////////////////////////////////////////////////
  // Pattern table
  ////////////////////////////////////////////////////
  // Bits 7:0 of each entry hold the newest byte of the pattern
  localparam logic [PAT_MAX_LEN*8-1:0] PAT_BYTES [NUM_PATTERNS] = '{
    {8'h00, "dog"},
    "cafe",
    {16'h0000, "ab"},
    // Same bin as "ab" so both hit on the final b
    {24'h000000, "b"},
    "fish",
    {8'h00, "gnu"},
    {16'h0000, "hq"},
    "wxyz",
    "kiwi",
    // Suffix of "wxyz" in the other bank
    {16'h0000, "yz"},
    "lime",
    {8'h00, "jet"},
    "opal",
    {16'h0000, "rv"},
    {8'h00, "sun"},
    "quiz"
  };

  localparam logic [2:0] PAT_LEN [NUM_PATTERNS] = '{
    3'd3, 3'd4, 3'd2, 3'd1,
    3'd4, 3'd3, 3'd2, 3'd4,
    3'd4, 3'd2, 3'd4, 3'd3,
    3'd4, 3'd2, 3'd3, 3'd4
  };

endpackage
